//--- all.f
verilog/mem_hub_pkg.sv
verilog/single_port_lutram.sv
verilog/fifo_queue.sv
verilog/request_arbiter.sv
verilog/backing_memory.sv
verilog/mem_request_hub.sv
dv/mem_request_hub_assertions.sv
dv/mem_request_hub_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run the regression"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/Vmem_request_hub_tb: all.f $(wildcard verilog/*.sv dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module mem_request_hub_tb

test: obj_dir/Vmem_request_hub_tb
	./obj_dir/Vmem_request_hub_tb > sim.log 2>&1 || echo "Regression failed" >> sim.log
	@cat sim.log
	@grep -q "Regression passed" sim.log || echo "Regression failed" >> sim.log
	@! grep -q "Regression failed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/mem_request_hub_tb.sv
`timescale 1ns/1ps

module mem_request_hub_tb;

    import mem_hub_pkg::*;

    localparam int total_items  = 128;   // items over all five tests.
    localparam int limit_cycles = total_items * 20 + 400;
    localparam int stall_items  = resp_queue_size + 1 + 2 * req_queue_size;   // all the hub holds.

    logic                  clk_in;
    logic                  reset_in;
    mem_request_t          port_request [2];
    logic [1:0]            port_valid;
    logic [1:0]            port_ack;
    logic [1:0]            port_full;
    mem_response_t         response;
    logic                  response_valid;
    logic                  response_ack;
    logic                  response_empty;

    logic [15:0]           lfsr_state = 16'd67;
    logic [data_width-1:0] model_words [mem_words];
    mem_response_t         expected_0 [$];
    mem_response_t         expected_1 [$];
    logic                  hold_response;
    logic                  no_delay;
    logic                  check_alternation;
    logic                  last_known;
    logic                  last_port;
    int                    error_count;
    int                    errors_at_start;
    int                    tests_ok;
    int                    tests_bad;
    int                    response_count;

    mem_request_hub u_dut
    (
        .clk_in (clk_in), .reset_in (reset_in),
        .port_0_request (port_request[0]), .port_0_valid (port_valid[0]),
        .port_0_ack (port_ack[0]), .port_0_full (port_full[0]),
        .port_1_request (port_request[1]), .port_1_valid (port_valid[1]),
        .port_1_ack (port_ack[1]), .port_1_full (port_full[1]),
        .response (response), .response_valid (response_valid),
        .response_ack (response_ack), .response_empty (response_empty)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    initial
    begin
        repeat (limit_cycles) @(posedge clk_in);
        $display("watchdog: the tests did not finish within %0d cycles", limit_cycles);
        $display("Regression failed");
        $finish;
    end

    // galois lfsr, one step per bit taken.
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // ******************************
    // response side
    // ******************************

    task automatic check_response();
        mem_response_t exp;
        logic          found;
        logic          both_pending;
        both_pending = (expected_0.size() != 0) && (expected_1.size() != 0);
        found        = 1'b1;
        if (response.port_id == 1'b0 && expected_0.size() != 0)
            exp = expected_0.pop_front();
        else if (response.port_id == 1'b1 && expected_1.size() != 0)
            exp = expected_1.pop_front();
        else
            found = 1'b0;
        response_count++;
        if (!found)
        begin
            error_count++;
            $display("response on port %0d addr %0d arrived with nothing outstanding",
                     response.port_id, response.addr);
        end
        else if (response != exp)
        begin
            error_count++;
            $display("FAIL %0t: port %0d addr %0d data %h, expected port %0d addr %0d data %h",
                     $time, response.port_id, response.addr, response.data,
                     exp.port_id, exp.addr, exp.data);
        end
        if (check_alternation && both_pending && last_known && response.port_id == last_port)
        begin
            error_count++;
            $display("FAIL %0t: port %0d answered twice running while both waited",
                     $time, response.port_id);
        end
        last_port  = response.port_id;
        last_known = 1'b1;
    endtask

    initial
    begin : consumer
        int delay;
        forever
        begin
            @(posedge clk_in);
            #1;
            response_ack = 1'b0;
            if (response_valid && !hold_response)
            begin
                delay = no_delay ? 0 : int'(random_bits(2));   // 0 to 3 cycles.
                repeat (delay)
                begin
                    @(posedge clk_in);
                    #1;
                end
                check_response();
                response_ack = 1'b1;
            end
        end
    end

    // ******************************
    // request side
    // ******************************

    task automatic send_request(input int port, input mem_request_t req);
        mem_response_t exp;
        @(posedge clk_in);
        #1;
        port_request[port] = req;
        port_valid[port]   = 1'b1;
        do
        begin
            @(posedge clk_in);
            #1;
        end
        while (!port_ack[port]);
        port_valid[port] = 1'b0;   // dropped for the ack cycle.
        exp.port_id = port[0];
        exp.addr    = req.addr;
        exp.data    = model_words[req.addr];
        if (req.is_write)
            model_words[req.addr] = req.data;
        else if (port == 0)
            expected_0.push_back(exp);
        else
            expected_1.push_back(exp);
    endtask

    // mode 0 reads the port's addresses in order, 1 mixes reads and writes, 2 reads at random.
    task automatic run_port(input int port, input int count, input int mode);
        mem_request_t req;
        logic [31:0]  rnd;
        for (int n = 0; n < count; n++)
        begin
            rnd          = random_bits(1);
            req.port_id  = rnd[0];   // the hub must overwrite it.
            rnd          = random_bits(1);
            req.is_write = (mode == 1) ? rnd[0] : 1'b0;
            rnd          = random_bits(3);
            req.addr     = (mode == 0) ? {port[0], n[2:0]} : {port[0], rnd[2:0]};
            req.data     = random_bits(32);
            send_request(port, req);
        end
    endtask

    task automatic wait_for_drain();
        while (expected_0.size() != 0 || expected_1.size() != 0)
        begin
            @(posedge clk_in);
            #1;
        end
        repeat (2) @(posedge clk_in);
    endtask

    task automatic finish_test(input string name);
        if (error_count == errors_at_start)
        begin
            tests_ok++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_bad++;
            $display("test %s: %0d errors", name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    initial
    begin
        reset_in          = 1'b1;
        port_request[0]   = '0;
        port_request[1]   = '0;
        port_valid        = 2'b00;
        response_ack      = 1'b0;
        hold_response     = 1'b0;
        no_delay          = 1'b0;
        check_alternation = 1'b0;
        last_known        = 1'b0;
        last_port         = 1'b0;
        error_count       = 0;
        errors_at_start   = 0;
        tests_ok          = 0;
        tests_bad         = 0;
        response_count    = 0;
        for (int i = 0; i < mem_words; i++)
            model_words[i] = '0;
        repeat (3) @(posedge clk_in);
        #1;
        reset_in = 1'b0;

        if (response_valid || port_ack != 2'b00 || !response_empty)
        begin
            error_count++;
            $display("FAIL %0t: outputs not idle after reset", $time);
        end
        fork
            run_port(0, 8, 0);
            run_port(1, 8, 0);
        join
        wait_for_drain();
        finish_test("1 reset and zero reads");

        run_port(0, 24, 1);
        wait_for_drain();
        finish_test("2 port 0 random reads and writes");

        fork
            run_port(0, 16, 2);
            run_port(1, 16, 2);
        join
        wait_for_drain();
        finish_test("3 both ports reading");

        no_delay          = 1'b1;
        check_alternation = 1'b1;
        last_known        = 1'b0;
        fork
            run_port(0, 16, 2);
            run_port(1, 16, 2);
        join
        wait_for_drain();
        no_delay          = 1'b0;
        check_alternation = 1'b0;
        finish_test("4 round-robin alternation");

        hold_response = 1'b1;
        fork
            run_port(0, 12, 2);
            run_port(1, 12, 2);
            begin
                while (expected_0.size() + expected_1.size() < stall_items)
                begin
                    @(posedge clk_in);
                    #1;
                end
                @(posedge clk_in);   // last ack pulse before the stall.
                #1;
                repeat (8)
                begin
                    if (port_ack != 2'b00 || port_full != 2'b11)
                    begin
                        error_count++;
                        $display("FAIL %0t: port ack %b full %b while the hub is stalled",
                                 $time, port_ack, port_full);
                    end
                    @(posedge clk_in);
                    #1;
                end
                hold_response = 1'b0;
            end
        join
        wait_for_drain();
        finish_test("5 back-pressure");

        $display("tests: %0d ok, %0d with errors; responses: %0d; errors: %0d",
                 tests_ok, tests_bad, response_count, error_count);
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- dv/mem_request_hub_assertions.sv
`timescale 1ns/1ps

module mem_request_hub_assertions
(
    input logic clk_in,
    input logic reset_in,
    input logic is_empty,
    input logic is_full,
    input logic issue_ack_out,
    input logic request_valid_out,
    input logic issue_ack_in
);

    // ******************************
    // queue handshake
    // ******************************

    a_ack_out_single: assert property (@(posedge clk_in) disable iff (reset_in)
        issue_ack_out |=> !issue_ack_out)
        else $error("issue_ack_out high two cycles running");

    // consumer may only take a head that is shown.
    a_ack_in_with_valid: assert property (@(posedge clk_in) disable iff (reset_in)
        issue_ack_in |-> request_valid_out)
        else $error("issue_ack_in without request_valid_out");

    // a full queue takes a write only while its head leaves.
    a_full_blocks_write: assert property (@(posedge clk_in) disable iff (reset_in)
        (is_full && !issue_ack_in) |=> !issue_ack_out)
        else $error("full queue acked a write without a dequeue");

    a_empty_no_head: assert property (@(posedge clk_in) disable iff (reset_in)
        is_empty |-> !request_valid_out)
        else $error("request_valid_out high while the queue is empty");

endmodule

bind fifo_queue mem_request_hub_assertions u_assertions
(
    .clk_in (clk_in), .reset_in (reset_in), .is_empty (is_empty), .is_full (is_full),
    .issue_ack_out (issue_ack_out), .request_valid_out (request_valid_out),
    .issue_ack_in (issue_ack_in)
);

//--- verilog/mem_request_hub.sv
`timescale 1ns/1ps

module mem_request_hub
(
    input  logic                       clk_in,
    input  logic                       reset_in,

    input  mem_hub_pkg::mem_request_t  port_0_request,
    input  logic                       port_0_valid,
    output logic                       port_0_ack,
    output logic                       port_0_full,

    input  mem_hub_pkg::mem_request_t  port_1_request,
    input  logic                       port_1_valid,
    output logic                       port_1_ack,
    output logic                       port_1_full,

    output mem_hub_pkg::mem_response_t response,
    output logic                       response_valid,
    input  logic                       response_ack,
    output logic                       response_empty
);

    import mem_hub_pkg::*;

    mem_request_t  tagged_0;
    mem_request_t  tagged_1;
    mem_request_t  head_0;
    mem_request_t  head_1;
    mem_request_t  issue_request;
    mem_response_t mem_response;
    logic          head_valid_0;
    logic          head_valid_1;
    logic          dequeue_0;
    logic          dequeue_1;
    logic          issue;
    logic          ready;
    logic          mem_response_valid;
    logic          mem_response_ack;

    // port number replaces whatever the client put in port_id.
    always_comb
    begin
        tagged_0         = port_0_request;
        tagged_0.port_id = 1'b0;
        tagged_1         = port_1_request;
        tagged_1.port_id = 1'b1;
    end

    // ******************************
    // request side
    // ******************************

    fifo_queue #(.payload_t(mem_request_t), .QUEUE_SIZE(req_queue_size),
                 .STORAGE_TYPE("FlipFlop")) u_req_queue_0
    (
        .clk_in (clk_in), .reset_in (reset_in), .is_empty (), .is_full (port_0_full),
        .request_in (tagged_0), .request_valid_in (port_0_valid), .issue_ack_out (port_0_ack),
        .request_out (head_0), .request_valid_out (head_valid_0), .issue_ack_in (dequeue_0)
    );

    fifo_queue #(.payload_t(mem_request_t), .QUEUE_SIZE(req_queue_size),
                 .STORAGE_TYPE("FlipFlop")) u_req_queue_1
    (
        .clk_in (clk_in), .reset_in (reset_in), .is_empty (), .is_full (port_1_full),
        .request_in (tagged_1), .request_valid_in (port_1_valid), .issue_ack_out (port_1_ack),
        .request_out (head_1), .request_valid_out (head_valid_1), .issue_ack_in (dequeue_1)
    );

    request_arbiter u_arbiter
    (
        .clk_in (clk_in), .reset_in (reset_in),
        .head_0 (head_0), .head_1 (head_1),
        .head_valid_0 (head_valid_0), .head_valid_1 (head_valid_1),
        .ack_0 (dequeue_0), .ack_1 (dequeue_1),
        .ready (ready), .issue (issue), .issue_request (issue_request)
    );

    // ******************************
    // memory and response side
    // ******************************

    backing_memory u_memory
    (
        .clk_in (clk_in), .reset_in (reset_in),
        .issue (issue), .issue_request (issue_request), .ready (ready),
        .response (mem_response), .response_valid (mem_response_valid),
        .response_ack (mem_response_ack)
    );

    fifo_queue #(.payload_t(mem_response_t), .QUEUE_SIZE(resp_queue_size),
                 .STORAGE_TYPE("LUTRAM")) u_resp_queue
    (
        .clk_in (clk_in), .reset_in (reset_in), .is_empty (response_empty), .is_full (),
        .request_in (mem_response), .request_valid_in (mem_response_valid),
        .issue_ack_out (mem_response_ack), .request_out (response),
        .request_valid_out (response_valid), .issue_ack_in (response_ack)
    );

endmodule

//--- verilog/backing_memory.sv
`timescale 1ns/1ps

module backing_memory
(
    input  logic                       clk_in,
    input  logic                       reset_in,

    input  logic                       issue,
    input  mem_hub_pkg::mem_request_t  issue_request,
    output logic                       ready,

    output mem_hub_pkg::mem_response_t response,
    output logic                       response_valid,
    input  logic                       response_ack
);

    import mem_hub_pkg::*;

    logic [data_width-1:0] words [mem_words];
    logic                  read_issue;
    logic                  write_issue;

    assign read_issue  = issue && !issue_request.is_write;
    assign write_issue = issue && issue_request.is_write;

    // busy while a read response waits for the queue.
    assign ready = !response_valid;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            response_valid <= 1'b0;
            for (int i = 0; i < mem_words; i++)
            begin
                words[i] <= '0;
            end
        end
        else
        begin
            if (write_issue)
            begin
                words[issue_request.addr] <= issue_request.data;
            end

            if (read_issue)
            begin
                response_valid <= 1'b1;
            end
            else if (response_ack)
            begin
                response_valid <= 1'b0;   // queue has taken it.
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (read_issue)
        begin
            response.port_id <= issue_request.port_id;
            response.addr    <= issue_request.addr;
            response.data    <= words[issue_request.addr];
        end
    end

endmodule

//--- verilog/request_arbiter.sv
`timescale 1ns/1ps

module request_arbiter
(
    input  logic                      clk_in,
    input  logic                      reset_in,

    input  mem_hub_pkg::mem_request_t head_0,
    input  mem_hub_pkg::mem_request_t head_1,
    input  logic                      head_valid_0,
    input  logic                      head_valid_1,
    output logic                      ack_0,
    output logic                      ack_1,

    input  logic                      ready,
    output logic                      issue,
    output mem_hub_pkg::mem_request_t issue_request
);

    logic last_grant;   // port that issued most recently.
    logic pick_1;

    // alternate when both heads wait, else take whichever is there.
    assign pick_1 = head_valid_1 && (!head_valid_0 || !last_grant);

    assign issue         = ready && (head_valid_0 || head_valid_1);
    assign issue_request = pick_1 ? head_1 : head_0;
    assign ack_0         = issue && !pick_1;
    assign ack_1         = issue && pick_1;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            last_grant <= 1'b1;   // port 0 goes first.
        end
        else if (issue)
        begin
            last_grant <= pick_1;
        end
    end

endmodule

//--- verilog/fifo_queue.sv
`timescale 1ns/1ps

module fifo_queue
#(
    parameter type   payload_t    = logic [31:0],
    parameter int    QUEUE_SIZE   = 4,
    parameter string STORAGE_TYPE = "FlipFlop"   // FlipFlop or LUTRAM.
)
(
    input  logic     clk_in,
    input  logic     reset_in,

    output logic     is_empty,
    output logic     is_full,

    input  payload_t request_in,
    input  logic     request_valid_in,
    output logic     issue_ack_out,

    output payload_t request_out,
    output logic     request_valid_out,
    input  logic     issue_ack_in
);

    localparam int ptr_width = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1;

    logic [QUEUE_SIZE-1:0] entry_valid;
    logic [ptr_width-1:0]  write_ptr;
    logic [ptr_width-1:0]  read_ptr;
    logic                  write_qualified;
    logic                  read_qualified;
    payload_t              head_entry;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        next_ptr = (ptr == ptr_width'(QUEUE_SIZE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign is_full  = &entry_valid;
    assign is_empty = ~|entry_valid;

    // ******************************
    // handshake qualification
    // ******************************

    assign read_qualified  = issue_ack_in && entry_valid[read_ptr];

    // a full queue still takes a write when the head leaves this cycle.
    assign write_qualified = (!is_full || read_qualified) && !issue_ack_out
                             && request_valid_in;

    // ******************************
    // pointers, valid bits, output
    // ******************************

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            entry_valid       <= '0;
            write_ptr         <= '0;
            read_ptr          <= '0;
            issue_ack_out     <= 1'b0;
            request_out       <= '0;
            request_valid_out <= 1'b0;
        end
        else
        begin
            issue_ack_out <= write_qualified;   // one-cycle pulse after the write.

            if (write_qualified)
            begin
                write_ptr <= next_ptr(write_ptr);
            end

            if (read_qualified)
            begin
                read_ptr          <= next_ptr(read_ptr);
                request_out       <= '0;
                request_valid_out <= 1'b0;   // low for a cycle while the pointer moves.
            end
            else if (entry_valid[read_ptr])
            begin
                request_out       <= head_entry;
                request_valid_out <= 1'b1;
            end
            else
            begin
                request_out       <= '0;
                request_valid_out <= 1'b0;
            end

            // a write wins over a read of the same slot.
            for (int i = 0; i < QUEUE_SIZE; i++)
            begin
                if (write_qualified && write_ptr == ptr_width'(i))
                begin
                    entry_valid[i] <= 1'b1;
                end
                else if (read_qualified && read_ptr == ptr_width'(i))
                begin
                    entry_valid[i] <= 1'b0;
                end
            end
        end
    end

    // ******************************
    // storage
    // ******************************

    if (STORAGE_TYPE == "LUTRAM")
    begin : g_lutram
        single_port_lutram
        #(
            .entry_t     (payload_t),
            .ENTRIES     (QUEUE_SIZE)
        )
        u_storage
        (
            .clk_in      (clk_in),
            .reset_in    (reset_in),
            .write_en    (write_qualified),
            .write_addr  (write_ptr),
            .write_entry (request_in),
            .read_addr   (read_ptr),
            .read_entry  (head_entry)
        );
    end
    else
    begin : g_flip_flop
        payload_t entry_array [QUEUE_SIZE];

        for (genvar i = 0; i < QUEUE_SIZE; i++)
        begin : g_entry
            always_ff @(posedge clk_in)
            begin
                if (write_qualified && write_ptr == ptr_width'(i))
                begin
                    entry_array[i] <= request_in;
                end
            end
        end

        assign head_entry = entry_array[read_ptr];
    end

endmodule

//--- verilog/single_port_lutram.sv
`timescale 1ns/1ps

module single_port_lutram
#(
    parameter type entry_t = logic [31:0],
    parameter int  ENTRIES = 8
)
(
    input  logic                                      clk_in,
    input  logic                                      reset_in,

    input  logic                                      write_en,
    input  logic [((ENTRIES > 1) ? $clog2(ENTRIES) : 1)-1:0] write_addr,
    input  entry_t                                    write_entry,

    input  logic [((ENTRIES > 1) ? $clog2(ENTRIES) : 1)-1:0] read_addr,
    output entry_t                                    read_entry
);

    entry_t entries [ENTRIES];   // contents undefined until written.

    logic write_allowed;

    // no writes land while the owner is held in reset.
    assign write_allowed = write_en && !reset_in;

    always_ff @(posedge clk_in)
    begin
        if (write_allowed)
        begin
            entries[write_addr] <= write_entry;
        end
    end

    // asynchronous read port.
    assign read_entry = entries[read_addr];

endmodule

//--- verilog/mem_hub_pkg.sv
package mem_hub_pkg;

    // ******************************
    // sizes
    // ******************************

    localparam int addr_width      = 4;   // word address.
    localparam int mem_words       = 16;
    localparam int data_width      = 32;
    localparam int req_queue_size  = 4;   // per client port.
    localparam int resp_queue_size = 8;

    // ******************************
    // payloads
    // ******************************

    typedef struct packed
    {
        logic                    port_id;   // overwritten by the hub.
        logic                    is_write;
        logic [addr_width-1:0]   addr;
        logic [data_width-1:0]   data;      // ignored on reads.
    } mem_request_t;

    // reads only; writes complete silently.
    typedef struct packed
    {
        logic                    port_id;
        logic [addr_width-1:0]   addr;
        logic [data_width-1:0]   data;
    } mem_response_t;

endpackage
